// ==== list.f ====
rtl/db_proto_pkg.sv
rtl/db_route_pkg.sv
rtl/db_prio_arbiter.sv
rtl/db_ctrl_mux.sv
rtl/db_ctrl_demux.sv
rtl/db_ctrl_fabric.sv
bench/db_periph_model.sv
bench/tb_db_ctrl_fabric.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the bench with Verilator, runs it and exits non-zero unless it passed

if ! cd "$(dirname "$0")"; then
    echo "cannot enter the project root"
    exit 1
fi

if ! verilator --binary --timing --assert --top-module tb_db_ctrl_fabric \
        -f list.f --Mdir obj_dir -o tb_sim; then
    echo "Verilator build failed"
    exit 1
fi

output="$(./obj_dir/tb_sim)"
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Simulation finished: PASS"; then
    exit 0
fi
exit 1

// ==== bench/tb_db_ctrl_fabric.sv ====
/*
 * Bench for the fabric with four modelled peripherals, each acking 3 cycles after accept.
 * Every controller ack is checked against a bench-side store; the first error stops the run.
 */
`timescale 1ns/1ps

module tb_db_ctrl_fabric;

    localparam int NUM_PERIPH = 4;
    localparam int ROUTE_WID  = $clog2(NUM_PERIPH);
    localparam int TIMEOUT    = 200;
    localparam int NUM_RAND   = 200;

    logic                   clk = 1'b0;
    logic                   srst;
    logic                   hi_req;
    logic                   lo_req;
    db_proto_pkg::db_req_t  hi_cmd;
    db_proto_pkg::db_req_t  lo_cmd;
    logic                   hi_rdy;
    logic                   lo_rdy;
    logic                   hi_ack;
    logic                   lo_ack;
    db_proto_pkg::db_resp_t hi_resp;
    db_proto_pkg::db_resp_t lo_resp;
    logic [NUM_PERIPH-1:0]  p_req;
    db_proto_pkg::db_req_t  p_cmd;
    logic [NUM_PERIPH-1:0]  p_rdy;
    logic [NUM_PERIPH-1:0]  p_ack;
    db_proto_pkg::db_resp_t p_resp [NUM_PERIPH];

    // Reference store, updated in ack order
    db_proto_pkg::value_t   ref_value   [2**db_proto_pkg::KEY_WID];
    logic                   ref_present [2**db_proto_pkg::KEY_WID];

    db_proto_pkg::db_req_t  hi_open;
    db_proto_pkg::db_req_t  lo_open;
    int                     hi_issued = 0;
    int                     lo_issued = 0;
    int                     hi_acked = 0;
    int                     lo_acked = 0;
    logic [NUM_PERIPH-1:0]  p_seen = '0;
    logic [NUM_PERIPH-1:0]  p_req_prev = '0;
    db_proto_pkg::key_t     req_key_log [$];
    logic [31:0]            rng;
    db_proto_pkg::db_req_t  rand_cmd [NUM_RAND];
    logic [1:0]             rand_gap [NUM_RAND];

    db_ctrl_fabric #(
        .NUM_PERIPH (NUM_PERIPH)
    ) dut (
        .clk     (clk),
        .srst    (srst),
        .hi_req  (hi_req),
        .lo_req  (lo_req),
        .hi_cmd  (hi_cmd),
        .lo_cmd  (lo_cmd),
        .hi_rdy  (hi_rdy),
        .lo_rdy  (lo_rdy),
        .hi_ack  (hi_ack),
        .lo_ack  (lo_ack),
        .hi_resp (hi_resp),
        .lo_resp (lo_resp),
        .p_req   (p_req),
        .p_cmd   (p_cmd),
        .p_rdy   (p_rdy),
        .p_ack   (p_ack),
        .p_resp  (p_resp)
    );

    for (genvar i = 0; i < NUM_PERIPH; i++) begin : g_periph
        db_periph_model #(
            .ACK_DELAY (3)
        ) u_periph (
            .clk  (clk),
            .srst (srst),
            .req  (p_req[i]),
            .cmd  (p_cmd),
            .rdy  (p_rdy[i]),
            .ack  (p_ack[i]),
            .resp (p_resp[i])
        );
    end

    always #10 clk = ~clk;

    // ==================================================
    // Reference model and checks
    // ==================================================
    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic db_proto_pkg::db_req_t make_cmd(input db_proto_pkg::command_t c,
                                                       input db_proto_pkg::key_t k,
                                                       input db_proto_pkg::value_t v);
        db_proto_pkg::db_req_t r;
        r.command   = c;
        r.key       = k;
        r.set_value = v;
        return r;
    endfunction

    function automatic db_proto_pkg::db_resp_t expected_resp(input db_proto_pkg::db_req_t r);
        db_proto_pkg::db_resp_t e;
        e = '0;
        e.status = db_proto_pkg::STATUS_OK;
        if (r.command == db_proto_pkg::COMMAND_NOP) begin
            e.status = db_proto_pkg::STATUS_ERROR;
        end else if (r.command == db_proto_pkg::COMMAND_GET) begin
            e.get_valid = ref_present[r.key];
            e.get_key   = r.key;
            e.get_value = ref_value[r.key];
        end
        return e;
    endfunction

    task automatic report_fail(input string what);
        $display("%s", what);
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp)
        else report_fail($sformatf("[ERROR] t=%0t %s got 0x%0h expected 0x%0h",
                                   $time, name, got, exp));
    endtask

    task automatic check_resp(input string port, input db_proto_pkg::db_req_t r,
                              input db_proto_pkg::db_resp_t got);
        db_proto_pkg::db_resp_t exp;
        exp = expected_resp(r);
        check_value({port, "_resp.status"}, 32'(got.status), 32'(exp.status));
        check_value({port, "_resp.get_valid"}, 32'(got.get_valid), 32'(exp.get_valid));
        if (r.command == db_proto_pkg::COMMAND_GET) begin
            check_value({port, "_resp.get_key"}, 32'(got.get_key), 32'(exp.get_key));
        end
        // Value only means something for a hit
        if (exp.get_valid) begin
            check_value({port, "_resp.get_value"}, got.get_value, exp.get_value);
        end
        if (r.command == db_proto_pkg::COMMAND_SET) begin
            ref_value[r.key]   = r.set_value;
            ref_present[r.key] = 1'b1;
        end else if (r.command == db_proto_pkg::COMMAND_UNSET) begin
            ref_present[r.key] = 1'b0;
        end
    endtask

    task automatic check_quiet();
        assert (hi_ack === 1'b0 && lo_ack === 1'b0 && p_req === '0)
        else report_fail("an ack or a peripheral request was active during or just after reset");
    endtask

    // Compare process, one ack per transaction
    always @(negedge clk) begin
        if (!srst && hi_ack === 1'b1) begin
            hi_acked++;
            check_resp("hi", hi_open, hi_resp);
        end
        if (!srst && lo_ack === 1'b1) begin
            lo_acked++;
            check_resp("lo", lo_open, lo_resp);
        end
    end

    // Routing monitor
    always @(negedge clk) begin
        if (!srst && p_req != '0) begin
            assert (p_req == (NUM_PERIPH'(1) << p_cmd.key[db_proto_pkg::KEY_WID-1 -: ROUTE_WID]))
            else report_fail("peripheral request raised on a port that does not match the key");
            p_seen = p_seen | p_req;
            if (p_req_prev == '0) begin
                req_key_log.push_back(p_cmd.key);
            end
        end
        p_req_prev = srst ? '0 : p_req;
    end

    // ==================================================
    // Controller driver
    // ==================================================
    task automatic run_txn(input logic is_hi, input db_proto_pkg::db_req_t cmd,
                           output time ack_at);
        int   waited;
        logic seen;
        @(posedge clk);
        #2;
        if (is_hi) begin
            hi_open = cmd;
            hi_cmd  = cmd;
            hi_req  = 1'b1;
        end else begin
            lo_open = cmd;
            lo_cmd  = cmd;
            lo_req  = 1'b1;
        end
        waited = 0;
        seen   = 1'b0;
        while (!seen && waited < TIMEOUT) begin
            @(negedge clk);
            seen = is_hi ? hi_rdy : lo_rdy;
            waited++;
        end
        assert (seen) else report_fail("controller request was never accepted");
        // Accepted on this edge
        @(posedge clk);
        #2;
        if (is_hi) begin
            hi_req = 1'b0;
            hi_issued++;
        end else begin
            lo_req = 1'b0;
            lo_issued++;
        end
        waited = 0;
        seen   = 1'b0;
        while (!seen && waited < TIMEOUT) begin
            @(negedge clk);
            seen = is_hi ? hi_ack : lo_ack;
            // rdy stays low until the ack of the open transaction
            if (!seen) begin
                assert ((is_hi ? hi_rdy : lo_rdy) === 1'b0)
                else report_fail("controller rdy rose before its ack came back");
            end
            waited++;
        end
        assert (seen) else report_fail("no ack came back for an accepted request");
        ack_at = $time;
    endtask

    task automatic play_stream(input logic is_hi);
        time t;
        for (int n = is_hi ? 0 : 1; n < NUM_RAND; n += 2) begin
            repeat (rand_gap[n]) @(posedge clk);
            run_txn(is_hi, rand_cmd[n], t);
        end
    endtask

    // Cycle limit for the whole run
    initial begin
        for (int c = 0; c < 20000; c++) begin
            @(posedge clk);
        end
        report_fail("simulation ran past its cycle limit");
    end

    // ==================================================
    // Main sequence
    // ==================================================
    initial begin
        time t_hi;
        time t_lo;
        int  n_before;
        srst   = 1'b1;
        hi_req = 1'b0;
        lo_req = 1'b0;
        hi_cmd = '0;
        lo_cmd = '0;
        for (int k = 0; k < 2**db_proto_pkg::KEY_WID; k++) begin
            ref_value[k]   = '0;
            ref_present[k] = 1'b0;
        end
        repeat (16) begin
            @(negedge clk);
            check_quiet();
        end
        @(posedge clk);
        #2;
        srst = 1'b0;
        // Release cycle and the first cycle clocked out of reset
        repeat (2) begin
            @(negedge clk);
            check_quiet();
        end

        // Write then read back on lo
        run_txn(1'b0, make_cmd(db_proto_pkg::COMMAND_SET, 8'h12, 32'hcafe_0012), t_lo);
        run_txn(1'b0, make_cmd(db_proto_pkg::COMMAND_GET, 8'h12, '0), t_lo);

        // One miss per peripheral
        for (int i = 0; i < NUM_PERIPH; i++) begin
            run_txn(1'b0, make_cmd(db_proto_pkg::COMMAND_GET, {i[1:0], 6'h2a}, '0), t_lo);
        end
        assert (p_seen == '1) else report_fail("not every peripheral received a request");

        // Both controllers ask in the same cycle
        n_before = req_key_log.size();
        fork
            run_txn(1'b1, make_cmd(db_proto_pkg::COMMAND_SET, 8'h81, 32'h0000_beef), t_hi);
            run_txn(1'b0, make_cmd(db_proto_pkg::COMMAND_SET, 8'h41, 32'h0000_f00d), t_lo);
        join
        assert (req_key_log.size() > n_before && req_key_log[n_before] == 8'h81)
        else report_fail("first peripheral request did not carry the hi controller key");
        assert (t_lo > t_hi) else report_fail("lo controller was acked before hi");

        run_txn(1'b1, make_cmd(db_proto_pkg::COMMAND_UNSET, 8'h81, '0), t_hi);
        run_txn(1'b1, make_cmd(db_proto_pkg::COMMAND_GET, 8'h81, '0), t_hi);
        run_txn(1'b1, make_cmd(db_proto_pkg::COMMAND_NOP, 8'h81, '0), t_hi);

        // Random stream, keys folded onto 32 values so that GETs hit
        rng = 32'hd4fa;
        for (int n = 0; n < NUM_RAND; n++) begin
            rng = lcg_next(rng);
            rand_cmd[n].command = db_proto_pkg::command_t'(rng[25:24]);
            rand_cmd[n].key     = {rng[31:30], 3'b000, rng[18:16]};
            rand_gap[n]         = rng[29:28];
            rng = lcg_next(rng);
            rand_cmd[n].set_value = rng;
        end
        fork
            play_stream(1'b1);
            play_stream(1'b0);
        join
        @(posedge clk);
        check_value("hi ack count", 32'(hi_acked), 32'(hi_issued));
        check_value("lo ack count", 32'(lo_acked), 32'(lo_issued));
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule : tb_db_ctrl_fabric

// ==== bench/db_periph_model.sv ====
/*
 * Behavioral key-value store behind one peripheral port, for simulation only.
 * Acks ACK_DELAY cycles after accepting (ACK_DELAY at least 1), rdy stays low until then.
 */
`timescale 1ns/1ps

module db_periph_model #(
    parameter int ACK_DELAY = 3
) (
    input  logic                   clk,
    input  logic                   srst,
    input  logic                   req,
    input  db_proto_pkg::db_req_t  cmd,
    output logic                   rdy,
    output logic                   ack,
    output db_proto_pkg::db_resp_t resp
);

    db_proto_pkg::value_t  store   [2**db_proto_pkg::KEY_WID];
    logic                  present [2**db_proto_pkg::KEY_WID];
    db_proto_pkg::db_req_t held;
    int                    count;

    // Answer for the held command, store contents before this command applies
    function automatic db_proto_pkg::db_resp_t answer(input db_proto_pkg::db_req_t r);
        db_proto_pkg::db_resp_t a;
        a = '0;
        a.status = db_proto_pkg::STATUS_OK;
        if (r.command == db_proto_pkg::COMMAND_NOP) begin
            a.status = db_proto_pkg::STATUS_ERROR;
        end else if (r.command == db_proto_pkg::COMMAND_GET) begin
            a.get_valid = present[r.key];
            a.get_key   = r.key;
            a.get_value = present[r.key] ? store[r.key] : '0;
        end
        return a;
    endfunction

    always @(posedge clk) begin
        if (srst) begin
            rdy   <= 1'b0;
            ack   <= 1'b0;
            resp  <= '0;
            count <= 0;
            for (int k = 0; k < 2**db_proto_pkg::KEY_WID; k++) begin
                present[k] <= 1'b0;
            end
        end else begin
            ack <= 1'b0;
            if (rdy && req) begin
                rdy   <= 1'b0;
                held  <= cmd;
                count <= ACK_DELAY;
            end else if (count > 1) begin
                count <= count - 1;
            end else if (count == 1) begin
                count <= 0;
                ack   <= 1'b1;
                resp  <= answer(held);
                if (held.command == db_proto_pkg::COMMAND_SET) begin
                    store[held.key]   <= held.set_value;
                    present[held.key] <= 1'b1;
                end else if (held.command == db_proto_pkg::COMMAND_UNSET) begin
                    present[held.key] <= 1'b0;
                end
            end else begin
                // Idle again one cycle after the ack
                rdy <= 1'b1;
            end
        end
    end

endmodule : db_periph_model

// ==== rtl/db_ctrl_fabric.sv ====
/*
 * Two controllers sharing NUM_PERIPH key-routed peripherals, hi has strict priority.
 * Controller ack comes at least 2 cycles after the peripheral's ack.
 */
`timescale 1ns/1ps

module db_ctrl_fabric #(
    parameter int NUM_PERIPH = 4
) (
    input  logic                   clk,
    input  logic                   srst,
    // Controllers
    input  logic                   hi_req,
    input  logic                   lo_req,
    input  db_proto_pkg::db_req_t  hi_cmd,
    input  db_proto_pkg::db_req_t  lo_cmd,
    output logic                   hi_rdy,
    output logic                   lo_rdy,
    output logic                   hi_ack,
    output logic                   lo_ack,
    output db_proto_pkg::db_resp_t hi_resp,
    output db_proto_pkg::db_resp_t lo_resp,
    // Peripherals
    output logic [NUM_PERIPH-1:0]  p_req,
    output db_proto_pkg::db_req_t  p_cmd,
    input  logic [NUM_PERIPH-1:0]  p_rdy,
    input  logic [NUM_PERIPH-1:0]  p_ack,
    input  db_proto_pkg::db_resp_t p_resp [NUM_PERIPH]
);

    db_route_pkg::ctrl_port_e sel;
    logic                     open_txn;
    logic                     dn_req;
    db_proto_pkg::db_req_t    dn_cmd;
    logic                     dn_rdy;
    logic                     dn_ack;
    db_proto_pkg::db_resp_t   dn_resp;

    db_prio_arbiter u_arbiter (
        .clk      (clk),
        .srst     (srst),
        .hi_req   (hi_req),
        .lo_req   (lo_req),
        .open_txn (open_txn),
        .sel      (sel)
    );

    db_ctrl_mux u_mux (
        .clk      (clk),
        .srst     (srst),
        .sel      (sel),
        .hi_req   (hi_req),
        .lo_req   (lo_req),
        .hi_cmd   (hi_cmd),
        .lo_cmd   (lo_cmd),
        .hi_rdy   (hi_rdy),
        .lo_rdy   (lo_rdy),
        .hi_ack   (hi_ack),
        .lo_ack   (lo_ack),
        .hi_resp  (hi_resp),
        .lo_resp  (lo_resp),
        .open_txn (open_txn),
        .dn_req   (dn_req),
        .dn_cmd   (dn_cmd),
        .dn_rdy   (dn_rdy),
        .dn_ack   (dn_ack),
        .dn_resp  (dn_resp)
    );

    db_ctrl_demux #(
        .NUM_PERIPH (NUM_PERIPH)
    ) u_demux (
        .clk     (clk),
        .srst    (srst),
        .up_req  (dn_req),
        .up_cmd  (dn_cmd),
        .up_rdy  (dn_rdy),
        .up_ack  (dn_ack),
        .up_resp (dn_resp),
        .p_req   (p_req),
        .p_cmd   (p_cmd),
        .p_rdy   (p_rdy),
        .p_ack   (p_ack),
        .p_resp  (p_resp)
    );

endmodule : db_ctrl_fabric

// ==== rtl/db_ctrl_demux.sv ====
/*
 * Routes one request at a time to the peripheral named by the top key bits.
 * NUM_PERIPH must be a power of two, at least 2, and no wider than the key allows.
 */
`timescale 1ns/1ps

module db_ctrl_demux #(
    parameter int NUM_PERIPH = 4
) (
    input  logic                   clk,
    input  logic                   srst,
    input  logic                   up_req,
    input  db_proto_pkg::db_req_t  up_cmd,
    output logic                   up_rdy,
    output logic                   up_ack,
    output db_proto_pkg::db_resp_t up_resp,
    output logic [NUM_PERIPH-1:0]  p_req,
    output db_proto_pkg::db_req_t  p_cmd,
    input  logic [NUM_PERIPH-1:0]  p_rdy,
    input  logic [NUM_PERIPH-1:0]  p_ack,
    input  db_proto_pkg::db_resp_t p_resp [NUM_PERIPH]
);

    localparam int ROUTE_WID = $clog2(NUM_PERIPH);

    logic                   accept;
    logic                   sel_rdy;
    logic                   sel_ack;
    logic                   pending;
    logic                   pending_nxt;
    logic                   rdy_q;
    logic                   req_q;
    logic                   ack_q;
    logic [ROUTE_WID-1:0]   route_q;
    db_proto_pkg::db_req_t  cmd_q;
    db_proto_pkg::db_resp_t resp_q;

    // ==================================================
    // Upstream acceptance
    // ==================================================
    assign accept = up_req && rdy_q;

    // Route index comes from the key MSBs
    always_ff @(posedge clk) begin
        if (srst) begin
            route_q <= '0;
        end else if (accept) begin
            route_q <= up_cmd.key[db_proto_pkg::KEY_WID-1 -: ROUTE_WID];
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            cmd_q <= up_cmd;
        end
    end

    // Stray acks from idle peripherals are ignored
    assign sel_rdy = p_rdy[route_q];
    assign sel_ack = p_ack[route_q] && pending;

    always_comb begin
        pending_nxt = pending;
        if (sel_ack) begin
            pending_nxt = 1'b0;
        end else if (accept) begin
            pending_nxt = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (srst) begin
            pending <= 1'b0;
            rdy_q   <= 1'b0;
            req_q   <= 1'b0;
            ack_q   <= 1'b0;
        end else begin
            pending <= pending_nxt;
            rdy_q   <= !pending_nxt;
            ack_q   <= sel_ack;
            if (accept) begin
                req_q <= 1'b1;
            end else if (req_q && sel_rdy) begin
                req_q <= 1'b0;
            end
        end
    end

    // ==================================================
    // Peripheral side
    // ==================================================
    always_comb begin
        for (int i = 0; i < NUM_PERIPH; i++) begin
            p_req[i] = req_q && (route_q == ROUTE_WID'(i));
        end
    end

    // Command bus is shared, req picks the target
    assign p_cmd = cmd_q;

    always_ff @(posedge clk) begin
        if (sel_ack) begin
            resp_q <= p_resp[route_q];
        end
    end

    assign up_rdy  = rdy_q;
    assign up_ack  = ack_q;
    assign up_resp = resp_q;

    // ==================================================
    // Checks
    // ==================================================
    a_one_target : assert property (
        @(posedge clk) disable iff (srst)
        $onehot0(p_req)
    ) else $error("request driven to more than one peripheral");

endmodule : db_ctrl_demux

// ==== rtl/db_ctrl_mux.sv ====
/*
 * Forwards the selected controller's request and returns ack and response to it.
 * One transaction at a time; rdy stays low from acceptance until the owner's ack.
 */
`timescale 1ns/1ps

module db_ctrl_mux (
    input  logic                     clk,
    input  logic                     srst,
    input  db_route_pkg::ctrl_port_e sel,
    input  logic                     hi_req,
    input  logic                     lo_req,
    input  db_proto_pkg::db_req_t    hi_cmd,
    input  db_proto_pkg::db_req_t    lo_cmd,
    output logic                     hi_rdy,
    output logic                     lo_rdy,
    output logic                     hi_ack,
    output logic                     lo_ack,
    output db_proto_pkg::db_resp_t   hi_resp,
    output db_proto_pkg::db_resp_t   lo_resp,
    output logic                     open_txn,
    output logic                     dn_req,
    output db_proto_pkg::db_req_t    dn_cmd,
    input  logic                     dn_rdy,
    input  logic                     dn_ack,
    input  db_proto_pkg::db_resp_t   dn_resp
);

    logic                   accept;
    logic                   done;
    logic                   pending;
    logic                   pending_nxt;
    logic                   rdy_q;
    logic                   dn_req_q;
    logic                   hi_ack_q;
    logic                   lo_ack_q;
    db_route_pkg::db_ctx_t  ctx;
    db_proto_pkg::db_resp_t resp_q;

    // ==================================================
    // Request side
    // ==================================================
    // Only the arbiter's choice ever sees rdy
    assign hi_rdy = rdy_q && (sel == db_route_pkg::PORT_HI);
    assign lo_rdy = rdy_q && (sel == db_route_pkg::PORT_LO);

    assign accept = (hi_req && hi_rdy) || (lo_req && lo_rdy);
    assign done   = dn_ack && pending;

    always_comb begin
        pending_nxt = pending;
        if (done) begin
            pending_nxt = 1'b0;
        end else if (accept) begin
            pending_nxt = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (srst) begin
            pending  <= 1'b0;
            rdy_q    <= 1'b0;
            dn_req_q <= 1'b0;
        end else begin
            pending <= pending_nxt;
            rdy_q   <= !pending_nxt;
            if (accept) begin
                dn_req_q <= 1'b1;
            end else if (dn_req_q && dn_rdy) begin
                dn_req_q <= 1'b0;
            end
        end
    end

    // Context is payload, valid while pending
    always_ff @(posedge clk) begin
        if (accept) begin
            ctx.owner <= sel;
            ctx.req   <= (sel == db_route_pkg::PORT_HI) ? hi_cmd : lo_cmd;
        end
    end

    assign open_txn = pending;
    assign dn_req   = dn_req_q;
    assign dn_cmd   = ctx.req;

    // ==================================================
    // Response side
    // ==================================================
    always_ff @(posedge clk) begin
        if (srst) begin
            hi_ack_q <= 1'b0;
            lo_ack_q <= 1'b0;
        end else begin
            hi_ack_q <= done && (ctx.owner == db_route_pkg::PORT_HI);
            lo_ack_q <= done && (ctx.owner == db_route_pkg::PORT_LO);
        end
    end

    always_ff @(posedge clk) begin
        if (done) begin
            resp_q <= dn_resp;
        end
    end

    assign hi_ack  = hi_ack_q;
    assign lo_ack  = lo_ack_q;
    // Both ports see the same word, only the owner gets ack
    assign hi_resp = resp_q;
    assign lo_resp = resp_q;

    // ==================================================
    // Checks
    // ==================================================
    a_ack_exclusive : assert property (
        @(posedge clk) disable iff (srst)
        !(hi_ack && lo_ack)
    ) else $error("ack returned to both controllers");

    a_no_overlap : assert property (
        @(posedge clk) disable iff (srst)
        $rose(dn_req) |-> !$past(open_txn)
    ) else $error("downstream request issued over an open transaction");

endmodule : db_ctrl_mux

// ==== rtl/db_prio_arbiter.sv ====
/*
 * Strict-priority pick between the two controllers, hi wins.
 * The pick is combinational while idle and frozen while open_txn is high.
 */
`timescale 1ns/1ps

module db_prio_arbiter (
    input  logic                     clk,
    input  logic                     srst,
    input  logic                     hi_req,
    input  logic                     lo_req,
    input  logic                     open_txn,
    output db_route_pkg::ctrl_port_e sel
);

    // Last granted controller, kept while a transaction is open
    db_route_pkg::ctrl_port_e sel_q;

    // ==================================================
    // Select
    // ==================================================
    always_comb begin
        if (open_txn) begin
            // Owner keeps the path until its ack is back
            sel = sel_q;
        end else if (hi_req) begin
            sel = db_route_pkg::PORT_HI;
        end else if (lo_req) begin
            sel = db_route_pkg::PORT_LO;
        end else begin
            // Nobody asking, park on the previous owner
            sel = sel_q;
        end
    end

    always_ff @(posedge clk) begin
        if (srst) begin
            sel_q <= db_route_pkg::PORT_HI;
        end else begin
            sel_q <= sel;
        end
    end

    // ==================================================
    // Checks
    // ==================================================
    // A transaction only opens for the picked controller while it asks
    a_owner_asked : assert property (
        @(posedge clk) disable iff (srst)
        $rose(open_txn) |->
            $past((sel == db_route_pkg::PORT_HI) ? hi_req : lo_req)
    ) else $error("transaction opened for a controller that was not asking");

endmodule : db_prio_arbiter

// ==== rtl/db_route_pkg.sv ====
/*
 * Routing types used inside the control fabric only.
 * Two controllers share the fabric, so the owner fits in one bit.
 */
package db_route_pkg;

    // ==================================================
    // Controller identity
    // ==================================================
    // PORT_HI always wins when both controllers ask at once
    typedef enum logic {
        PORT_HI = 1'b0,
        PORT_LO = 1'b1
    } ctrl_port_e;

    // ==================================================
    // Open transaction context
    // ==================================================
    // Captured by the mux when a controller request is accepted.
    // The owner steers ack and response back on completion,
    // the request word is what travels on toward the demux
    typedef struct packed {
        ctrl_port_e           owner;
        db_proto_pkg::db_req_t req;
    } db_ctx_t;

endpackage : db_route_pkg

// ==== rtl/db_proto_pkg.sv ====
/*
 * Key-value database protocol types shared by controllers, fabric and peripherals.
 * A response is only meaningful in the cycle its ack is high.
 */
package db_proto_pkg;

    // ==================================================
    // Widths
    // ==================================================
    localparam int KEY_WID   = 8;
    localparam int VALUE_WID = 32;

    typedef logic [KEY_WID-1:0]   key_t;
    typedef logic [VALUE_WID-1:0] value_t;

    // ==================================================
    // Encodings
    // ==================================================
    typedef enum logic [1:0] {
        COMMAND_NOP   = 2'd0,
        COMMAND_GET   = 2'd1,
        COMMAND_SET   = 2'd2,
        COMMAND_UNSET = 2'd3
    } command_t;

    // Code 3 is not used by any responder
    typedef enum logic [1:0] {
        STATUS_OK          = 2'd0,
        STATUS_ERROR       = 2'd1,
        STATUS_UNSPECIFIED = 2'd2
    } status_t;

    // ==================================================
    // Request and response words
    // ==================================================
    typedef struct packed {
        command_t command;
        key_t     key;
        value_t   set_value;
    } db_req_t;

    // get_key and get_value are only defined for GET
    typedef struct packed {
        status_t status;
        logic    get_valid;
        key_t    get_key;
        value_t  get_value;
    } db_resp_t;

endpackage : db_proto_pkg
